//--- logic/lsu_pkg.sv
// --------------------
// shared widths, operation codes and exception causes
// for the load/store unit, plus the memory data word union
// --------------------
`default_nettype none

package lsu_pkg;

    // --------------------
    // widths
    // --------------------
    localparam int unsigned XLEN          = 64;
    localparam int unsigned VLEN          = 39;
    localparam int unsigned PLEN          = 56;
    localparam int unsigned SV            = 39;
    localparam int unsigned TRANS_ID_BITS = 3;
    localparam int unsigned BE_W          = XLEN / 8;
    localparam int unsigned OP_W          = 4;
    localparam int unsigned CAUSE_W       = 6;

    // --------------------
    // operation codes
    // --------------------
    // bit 3 store, bits 1:0 size, bit 2 zero-extend on loads
    localparam logic [OP_W-1:0] LB  = 4'd0;
    localparam logic [OP_W-1:0] LH  = 4'd1;
    localparam logic [OP_W-1:0] LW  = 4'd2;
    localparam logic [OP_W-1:0] LD  = 4'd3;
    localparam logic [OP_W-1:0] LBU = 4'd4;
    localparam logic [OP_W-1:0] LHU = 4'd5;
    localparam logic [OP_W-1:0] LWU = 4'd6;
    localparam logic [OP_W-1:0] SB  = 4'd8;
    localparam logic [OP_W-1:0] SH  = 4'd9;
    localparam logic [OP_W-1:0] SW  = 4'd10;
    localparam logic [OP_W-1:0] SD  = 4'd11;

    // --------------------
    // exception causes
    // --------------------
    localparam logic [CAUSE_W-1:0] LD_ADDR_MISALIGNED = 6'd4;
    localparam logic [CAUSE_W-1:0] LD_ACCESS_FAULT    = 6'd5;
    localparam logic [CAUSE_W-1:0] ST_ADDR_MISALIGNED = 6'd6;
    localparam logic [CAUSE_W-1:0] ST_ACCESS_FAULT    = 6'd7;

    // memory word seen whole or as byte lanes
    typedef union packed {
        logic [XLEN-1:0]          dword;
        logic [BE_W-1:0][7:0]     bytes;
    } data_word_u;

endpackage

`default_nettype wire

//--- logic/address_gen.sv
// --------------------
// address generation: base plus immediate, Sv39 canonical check,
// byte enables and the stage-1 request register
// --------------------
`default_nettype none

module address_gen (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                flush_i,
    input  logic                                fu_valid_i,
    input  logic [lsu_pkg::OP_W-1:0]            fu_op_i,
    input  logic [lsu_pkg::XLEN-1:0]            fu_operand_a_i,
    input  logic [lsu_pkg::XLEN-1:0]            fu_imm_i,
    input  logic [lsu_pkg::XLEN-1:0]            fu_operand_b_i,
    input  logic [lsu_pkg::TRANS_ID_BITS-1:0]   fu_trans_id_i,
    output logic                                s1_valid_o,
    output logic [lsu_pkg::OP_W-1:0]            s1_op_o,
    output logic [lsu_pkg::VLEN-1:0]            s1_vaddr_o,
    output logic                                s1_overflow_o,
    output logic [lsu_pkg::BE_W-1:0]            s1_be_o,
    output logic [lsu_pkg::XLEN-1:0]            s1_wdata_o,
    output logic [lsu_pkg::TRANS_ID_BITS-1:0]   s1_trans_id_o
);

    logic [lsu_pkg::XLEN-1:0]         vaddr_xlen;
    logic [lsu_pkg::XLEN-lsu_pkg::SV:0] upper_bits;
    logic                             overflow;
    logic [lsu_pkg::BE_W-1:0]         size_mask;
    logic [lsu_pkg::BE_W-1:0]         be;

    // --------------------
    // AGU
    // --------------------
    assign vaddr_xlen = fu_operand_a_i + fu_imm_i;

    // bits from SV-1 upward must all match
    assign upper_bits = vaddr_xlen[lsu_pkg::XLEN-1:lsu_pkg::SV-1];
    assign overflow   = !((&upper_bits) || !(|upper_bits));

    // lanes covered by the transfer size
    always_comb begin
        case (fu_op_i[1:0])
            2'd0:    size_mask = 8'h01;
            2'd1:    size_mask = 8'h03;
            2'd2:    size_mask = 8'h0f;
            default: size_mask = 8'hff;
        endcase
    end

    assign be = size_mask << vaddr_xlen[2:0];

    // --------------------
    // stage-1 register
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            s1_valid_o <= 1'b0;
        end else begin
            s1_valid_o <= fu_valid_i && !flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        s1_op_o       <= fu_op_i;
        s1_vaddr_o    <= vaddr_xlen[lsu_pkg::VLEN-1:0];
        s1_overflow_o <= overflow;
        s1_be_o       <= be;
        s1_wdata_o    <= fu_operand_b_i;
        s1_trans_id_o <= fu_trans_id_i;
    end

    // no holes or codes past SD reach the pipe
    a_legal_op: assert property (@(posedge clk_i) disable iff (!rst_ni)
        fu_valid_i |-> (fu_op_i != 4'd7 && fu_op_i <= lsu_pkg::SD));

endmodule

`default_nettype wire

//--- logic/bare_mmu.sv
// --------------------
// misaligned and access-fault detection with identity
// translation, registered into stage 2
// --------------------
`default_nettype none

module bare_mmu (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                flush_i,
    input  logic                                en_ld_st_translation_i,
    input  logic                                s1_valid_i,
    input  logic [lsu_pkg::OP_W-1:0]            s1_op_i,
    input  logic [lsu_pkg::VLEN-1:0]            s1_vaddr_i,
    input  logic                                s1_overflow_i,
    input  logic [lsu_pkg::BE_W-1:0]            s1_be_i,
    input  logic [lsu_pkg::XLEN-1:0]            s1_wdata_i,
    input  logic [lsu_pkg::TRANS_ID_BITS-1:0]   s1_trans_id_i,
    output logic                                s2_valid_o,
    output logic [lsu_pkg::OP_W-1:0]            s2_op_o,
    output logic [lsu_pkg::PLEN-1:0]            s2_paddr_o,
    output logic [lsu_pkg::BE_W-1:0]            s2_be_o,
    output logic [lsu_pkg::XLEN-1:0]            s2_wdata_o,
    output logic [lsu_pkg::TRANS_ID_BITS-1:0]   s2_trans_id_o,
    output logic                                s2_ex_valid_o,
    output logic [lsu_pkg::CAUSE_W-1:0]         s2_ex_cause_o,
    output logic [lsu_pkg::XLEN-1:0]            s2_ex_tval_o
);

    logic                          is_store;
    logic                          misaligned;
    logic                          ex_valid;
    logic [lsu_pkg::CAUSE_W-1:0]   ex_cause;

    assign is_store = s1_op_i[lsu_pkg::OP_W-1];

    // --------------------
    // exception detection
    // --------------------
    always_comb begin
        case (s1_op_i[1:0])
            2'd1:    misaligned = s1_vaddr_i[0];
            2'd2:    misaligned = |s1_vaddr_i[1:0];
            2'd3:    misaligned = |s1_vaddr_i[2:0];
            default: misaligned = 1'b0;
        endcase
    end

    always_comb begin
        ex_valid = 1'b0;
        ex_cause = '0;
        if (misaligned) begin
            ex_valid = 1'b1;
            ex_cause = is_store ? lsu_pkg::ST_ADDR_MISALIGNED : lsu_pkg::LD_ADDR_MISALIGNED;
        end
        // a non-canonical address outranks misalignment
        if (en_ld_st_translation_i && s1_overflow_i) begin
            ex_valid = 1'b1;
            ex_cause = is_store ? lsu_pkg::ST_ACCESS_FAULT : lsu_pkg::LD_ACCESS_FAULT;
        end
    end

    // --------------------
    // stage-2 register
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            s2_valid_o    <= 1'b0;
            s2_ex_valid_o <= 1'b0;
        end else begin
            s2_valid_o    <= s1_valid_i && !flush_i;
            s2_ex_valid_o <= s1_valid_i && ex_valid && !flush_i;
        end
    end

    // identity mapping, physical address is the zero-extended vaddr
    always_ff @(posedge clk_i) begin
        s2_op_o       <= s1_op_i;
        s2_paddr_o    <= {{(lsu_pkg::PLEN-lsu_pkg::VLEN){1'b0}}, s1_vaddr_i};
        s2_be_o       <= s1_be_i;
        s2_wdata_o    <= s1_wdata_i;
        s2_trans_id_o <= s1_trans_id_i;
        s2_ex_cause_o <= ex_cause;
        s2_ex_tval_o  <= {{(lsu_pkg::XLEN-lsu_pkg::VLEN){1'b0}}, s1_vaddr_i};
    end

    // a clean op keeps all lanes of its size inside the double word
    a_clean_lanes_fit: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (s2_valid_o && !s2_ex_valid_o) |-> ($countones(s2_be_o) == (1 << s2_op_o[1:0])));

endmodule

`default_nettype wire

//--- logic/load_unit.sv
// --------------------
// load path: memory request, one pending-load register,
// lane selection and sign or zero extension
// --------------------
`default_nettype none

module load_unit (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                flush_i,
    input  logic                                s2_valid_i,
    input  logic [lsu_pkg::OP_W-1:0]            s2_op_i,
    input  logic [lsu_pkg::PLEN-1:0]            s2_paddr_i,
    input  logic [lsu_pkg::TRANS_ID_BITS-1:0]   s2_trans_id_i,
    input  logic                                s2_ex_valid_i,
    input  logic [lsu_pkg::CAUSE_W-1:0]         s2_ex_cause_i,
    input  logic [lsu_pkg::XLEN-1:0]            s2_ex_tval_i,
    input  logic [lsu_pkg::XLEN-1:0]            ld_mem_rdata_i,
    output logic                                ld_mem_req_o,
    output logic [lsu_pkg::PLEN-1:0]            ld_mem_addr_o,
    output logic                                load_valid_o,
    output logic [lsu_pkg::TRANS_ID_BITS-1:0]   load_trans_id_o,
    output logic [lsu_pkg::XLEN-1:0]            load_result_o,
    output logic                                load_ex_valid_o,
    output logic [lsu_pkg::CAUSE_W-1:0]         load_ex_cause_o,
    output logic [lsu_pkg::XLEN-1:0]            load_ex_tval_o
);

    logic                                is_load;
    logic                                pend_valid;
    logic                                pend_ex_valid;
    logic [lsu_pkg::TRANS_ID_BITS-1:0]   pend_trans_id;
    logic [2:0]                          pend_offset;
    logic [lsu_pkg::OP_W-1:0]            pend_op;
    logic [lsu_pkg::CAUSE_W-1:0]         pend_cause;
    logic [lsu_pkg::XLEN-1:0]            pend_tval;
    lsu_pkg::data_word_u                 lanes;
    logic [lsu_pkg::XLEN-1:0]            extended;

    // --------------------
    // request
    // --------------------
    assign is_load       = s2_valid_i && !s2_op_i[lsu_pkg::OP_W-1];
    assign ld_mem_req_o  = is_load && !s2_ex_valid_i;
    assign ld_mem_addr_o = {s2_paddr_i[lsu_pkg::PLEN-1:3], 3'b000};

    // --------------------
    // pending load
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pend_valid    <= 1'b0;
            pend_ex_valid <= 1'b0;
        end else begin
            pend_valid    <= is_load && !flush_i;
            pend_ex_valid <= is_load && s2_ex_valid_i && !flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        pend_trans_id <= s2_trans_id_i;
        pend_offset   <= s2_paddr_i[2:0];
        pend_op       <= s2_op_i;
        pend_cause    <= s2_ex_cause_i;
        pend_tval     <= s2_ex_tval_i;
    end

    // --------------------
    // result
    // --------------------
    // addressed byte moved down to lane 0
    assign lanes = ld_mem_rdata_i >> {pend_offset, 3'b000};

    always_comb begin
        case (pend_op)
            lsu_pkg::LB:  extended = {{56{lanes.bytes[0][7]}}, lanes.bytes[0]};
            lsu_pkg::LBU: extended = {56'd0, lanes.bytes[0]};
            lsu_pkg::LH:  extended = {{48{lanes.bytes[1][7]}}, lanes.bytes[1], lanes.bytes[0]};
            lsu_pkg::LHU: extended = {48'd0, lanes.bytes[1], lanes.bytes[0]};
            lsu_pkg::LW:  extended = {{32{lanes.bytes[3][7]}}, lanes.dword[31:0]};
            lsu_pkg::LWU: extended = {32'd0, lanes.dword[31:0]};
            default:      extended = lanes.dword;
        endcase
    end

    assign load_valid_o    = pend_valid;
    assign load_trans_id_o = pend_trans_id;
    assign load_result_o   = pend_ex_valid ? '0 : extended;
    assign load_ex_valid_o = pend_ex_valid;
    assign load_ex_cause_o = pend_cause;
    assign load_ex_tval_o  = pend_tval;

    // an issued read is a load whose bytes all sit in the returned word
    a_req_in_word: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ld_mem_req_o |-> (!s2_op_i[lsu_pkg::OP_W-1]
            && (int'(s2_paddr_i[2:0]) + (1 << s2_op_i[1:0]) <= 8)));

endmodule

`default_nettype wire

//--- logic/store_unit.sv
// --------------------
// store path: lane shift, memory write and completion
// --------------------
`default_nettype none

module store_unit (
    input  logic                                s2_valid_i,
    input  logic [lsu_pkg::OP_W-1:0]            s2_op_i,
    input  logic [lsu_pkg::PLEN-1:0]            s2_paddr_i,
    input  logic [lsu_pkg::BE_W-1:0]            s2_be_i,
    input  logic [lsu_pkg::XLEN-1:0]            s2_wdata_i,
    input  logic [lsu_pkg::TRANS_ID_BITS-1:0]   s2_trans_id_i,
    input  logic                                s2_ex_valid_i,
    input  logic [lsu_pkg::CAUSE_W-1:0]         s2_ex_cause_i,
    input  logic [lsu_pkg::XLEN-1:0]            s2_ex_tval_i,
    output logic                                st_mem_req_o,
    output logic [lsu_pkg::PLEN-1:0]            st_mem_addr_o,
    output logic [lsu_pkg::XLEN-1:0]            st_mem_wdata_o,
    output logic [lsu_pkg::BE_W-1:0]            st_mem_be_o,
    output logic                                store_valid_o,
    output logic [lsu_pkg::TRANS_ID_BITS-1:0]   store_trans_id_o,
    output logic                                store_ex_valid_o,
    output logic [lsu_pkg::CAUSE_W-1:0]         store_ex_cause_o,
    output logic [lsu_pkg::XLEN-1:0]            store_ex_tval_o
);

    logic                  is_store;
    lsu_pkg::data_word_u   src;
    lsu_pkg::data_word_u   lanes;

    assign is_store  = s2_valid_i && s2_op_i[lsu_pkg::OP_W-1];
    assign src.dword = s2_wdata_i;

    // byte i of operand_b goes to lane offset+i
    always_comb begin
        lanes = '0;
        for (int i = 0; i < lsu_pkg::BE_W; i++) begin
            if (i >= int'(s2_paddr_i[2:0])) begin
                lanes.bytes[i] = src.bytes[i - int'(s2_paddr_i[2:0])];
            end
        end
    end

    // --------------------
    // memory write
    // --------------------
    assign st_mem_req_o   = is_store && !s2_ex_valid_i;
    assign st_mem_addr_o  = {s2_paddr_i[lsu_pkg::PLEN-1:3], 3'b000};
    assign st_mem_wdata_o = lanes.dword;
    assign st_mem_be_o    = s2_be_i;

    // completion in the same cycle
    assign store_valid_o    = is_store;
    assign store_trans_id_o = s2_trans_id_i;
    assign store_ex_valid_o = is_store && s2_ex_valid_i;
    assign store_ex_cause_o = s2_ex_cause_i;
    assign store_ex_tval_o  = s2_ex_tval_i;

    always_comb begin
        if (st_mem_req_o) begin
            a_be_nonzero: assert (st_mem_be_o != '0);
        end
    end

endmodule

`default_nettype wire

//--- logic/load_store_unit.sv
// --------------------
// load/store unit top: AGU, bare MMU, load and store units
// --------------------
`default_nettype none

module load_store_unit (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                flush_i,
    input  logic                                en_ld_st_translation_i,
    input  logic                                fu_valid_i,
    input  logic [lsu_pkg::OP_W-1:0]            fu_op_i,
    input  logic [lsu_pkg::XLEN-1:0]            fu_operand_a_i,
    input  logic [lsu_pkg::XLEN-1:0]            fu_imm_i,
    input  logic [lsu_pkg::XLEN-1:0]            fu_operand_b_i,
    input  logic [lsu_pkg::TRANS_ID_BITS-1:0]   fu_trans_id_i,
    // load memory port
    output logic                                ld_mem_req_o,
    output logic [lsu_pkg::PLEN-1:0]            ld_mem_addr_o,
    input  logic [lsu_pkg::XLEN-1:0]            ld_mem_rdata_i,
    // store memory port
    output logic                                st_mem_req_o,
    output logic [lsu_pkg::PLEN-1:0]            st_mem_addr_o,
    output logic [lsu_pkg::XLEN-1:0]            st_mem_wdata_o,
    output logic [lsu_pkg::BE_W-1:0]            st_mem_be_o,
    // load results
    output logic                                load_valid_o,
    output logic [lsu_pkg::TRANS_ID_BITS-1:0]   load_trans_id_o,
    output logic [lsu_pkg::XLEN-1:0]            load_result_o,
    output logic                                load_ex_valid_o,
    output logic [lsu_pkg::CAUSE_W-1:0]         load_ex_cause_o,
    output logic [lsu_pkg::XLEN-1:0]            load_ex_tval_o,
    // store results
    output logic                                store_valid_o,
    output logic [lsu_pkg::TRANS_ID_BITS-1:0]   store_trans_id_o,
    output logic                                store_ex_valid_o,
    output logic [lsu_pkg::CAUSE_W-1:0]         store_ex_cause_o,
    output logic [lsu_pkg::XLEN-1:0]            store_ex_tval_o
);

    logic                                s1_valid;
    logic [lsu_pkg::OP_W-1:0]            s1_op;
    logic [lsu_pkg::VLEN-1:0]            s1_vaddr;
    logic                                s1_overflow;
    logic [lsu_pkg::BE_W-1:0]            s1_be;
    logic [lsu_pkg::XLEN-1:0]            s1_wdata;
    logic [lsu_pkg::TRANS_ID_BITS-1:0]   s1_trans_id;

    logic                                s2_valid;
    logic [lsu_pkg::OP_W-1:0]            s2_op;
    logic [lsu_pkg::PLEN-1:0]            s2_paddr;
    logic [lsu_pkg::BE_W-1:0]            s2_be;
    logic [lsu_pkg::XLEN-1:0]            s2_wdata;
    logic [lsu_pkg::TRANS_ID_BITS-1:0]   s2_trans_id;
    logic                                s2_ex_valid;
    logic [lsu_pkg::CAUSE_W-1:0]         s2_ex_cause;
    logic [lsu_pkg::XLEN-1:0]            s2_ex_tval;

    address_gen u_address_gen (
        .clk_i, .rst_ni, .flush_i,
        .fu_valid_i, .fu_op_i, .fu_operand_a_i, .fu_imm_i, .fu_operand_b_i, .fu_trans_id_i,
        .s1_valid_o    (s1_valid),
        .s1_op_o       (s1_op),
        .s1_vaddr_o    (s1_vaddr),
        .s1_overflow_o (s1_overflow),
        .s1_be_o       (s1_be),
        .s1_wdata_o    (s1_wdata),
        .s1_trans_id_o (s1_trans_id)
    );

    bare_mmu u_bare_mmu (
        .clk_i, .rst_ni, .flush_i, .en_ld_st_translation_i,
        .s1_valid_i    (s1_valid),
        .s1_op_i       (s1_op),
        .s1_vaddr_i    (s1_vaddr),
        .s1_overflow_i (s1_overflow),
        .s1_be_i       (s1_be),
        .s1_wdata_i    (s1_wdata),
        .s1_trans_id_i (s1_trans_id),
        .s2_valid_o    (s2_valid),
        .s2_op_o       (s2_op),
        .s2_paddr_o    (s2_paddr),
        .s2_be_o       (s2_be),
        .s2_wdata_o    (s2_wdata),
        .s2_trans_id_o (s2_trans_id),
        .s2_ex_valid_o (s2_ex_valid),
        .s2_ex_cause_o (s2_ex_cause),
        .s2_ex_tval_o  (s2_ex_tval)
    );

    // both units see stage 2 and keep their own ops
    load_unit u_load_unit (
        .clk_i, .rst_ni, .flush_i,
        .s2_valid_i    (s2_valid),
        .s2_op_i       (s2_op),
        .s2_paddr_i    (s2_paddr),
        .s2_trans_id_i (s2_trans_id),
        .s2_ex_valid_i (s2_ex_valid),
        .s2_ex_cause_i (s2_ex_cause),
        .s2_ex_tval_i  (s2_ex_tval),
        .ld_mem_rdata_i, .ld_mem_req_o, .ld_mem_addr_o,
        .load_valid_o, .load_trans_id_o, .load_result_o,
        .load_ex_valid_o, .load_ex_cause_o, .load_ex_tval_o
    );

    store_unit u_store_unit (
        .s2_valid_i    (s2_valid),
        .s2_op_i       (s2_op),
        .s2_paddr_i    (s2_paddr),
        .s2_be_i       (s2_be),
        .s2_wdata_i    (s2_wdata),
        .s2_trans_id_i (s2_trans_id),
        .s2_ex_valid_i (s2_ex_valid),
        .s2_ex_cause_i (s2_ex_cause),
        .s2_ex_tval_i  (s2_ex_tval),
        .st_mem_req_o, .st_mem_addr_o, .st_mem_wdata_o, .st_mem_be_o,
        .store_valid_o, .store_trans_id_o,
        .store_ex_valid_o, .store_ex_cause_o, .store_ex_tval_o
    );

endmodule

`default_nettype wire

//--- tb/tb_load_store_unit.sv
// --------------------
// testbench for the load/store unit: clock, reset, memory model,
// golden-file driver and result compare tasks
// --------------------
`default_nettype none

module tb_load_store_unit;

    localparam int unsigned FIELDS = 11;

    logic                                clk_i;
    logic                                rst_ni;
    logic                                flush_i;
    logic                                en_ld_st_translation_i;
    logic                                fu_valid_i;
    logic [lsu_pkg::OP_W-1:0]            fu_op_i;
    logic [lsu_pkg::XLEN-1:0]            fu_operand_a_i;
    logic [lsu_pkg::XLEN-1:0]            fu_imm_i;
    logic [lsu_pkg::XLEN-1:0]            fu_operand_b_i;
    logic [lsu_pkg::TRANS_ID_BITS-1:0]   fu_trans_id_i;
    logic                                ld_mem_req_o;
    logic [lsu_pkg::PLEN-1:0]            ld_mem_addr_o;
    logic [lsu_pkg::XLEN-1:0]            ld_mem_rdata_i;
    logic                                st_mem_req_o;
    logic [lsu_pkg::PLEN-1:0]            st_mem_addr_o;
    logic [lsu_pkg::XLEN-1:0]            st_mem_wdata_o;
    logic [lsu_pkg::BE_W-1:0]            st_mem_be_o;
    logic                                load_valid_o;
    logic [lsu_pkg::TRANS_ID_BITS-1:0]   load_trans_id_o;
    logic [lsu_pkg::XLEN-1:0]            load_result_o;
    logic                                load_ex_valid_o;
    logic [lsu_pkg::CAUSE_W-1:0]         load_ex_cause_o;
    logic [lsu_pkg::XLEN-1:0]            load_ex_tval_o;
    logic                                store_valid_o;
    logic [lsu_pkg::TRANS_ID_BITS-1:0]   store_trans_id_o;
    logic                                store_ex_valid_o;
    logic [lsu_pkg::CAUSE_W-1:0]         store_ex_cause_o;
    logic [lsu_pkg::XLEN-1:0]            store_ex_tval_o;

    logic [63:0]                         golden [0:511];
    lsu_pkg::data_word_u                 mem [0:63];
    logic                                ld_req_seen;
    int                                  num_ops;
    int                                  cycle_count;
    int                                  cycle_limit;
    int                                  seed;

    // expected results, one queue per field
    logic [lsu_pkg::TRANS_ID_BITS-1:0]   ld_tid_q[$];
    logic [lsu_pkg::XLEN-1:0]            ld_res_q[$];
    logic                                ld_ex_q[$];
    logic [lsu_pkg::CAUSE_W-1:0]         ld_cause_q[$];
    logic [lsu_pkg::XLEN-1:0]            ld_tval_q[$];
    logic [lsu_pkg::TRANS_ID_BITS-1:0]   st_tid_q[$];
    logic                                st_ex_q[$];
    logic [lsu_pkg::CAUSE_W-1:0]         st_cause_q[$];
    logic [lsu_pkg::XLEN-1:0]            st_tval_q[$];

    load_store_unit u_dut (.*);

    always #4 clk_i = ~clk_i;

    // --------------------
    // memory model
    // --------------------
    always @(posedge clk_i) begin
        if (st_mem_req_o) begin
            for (int j = 0; j < lsu_pkg::BE_W; j++) begin
                if (st_mem_be_o[j]) begin
                    mem[st_mem_addr_o[8:3]].bytes[j] <= st_mem_wdata_o[j*8 +: 8];
                end
            end
        end
        if (ld_mem_req_o) begin
            ld_mem_rdata_i <= mem[ld_mem_addr_o[8:3]].dword;
        end
        // read request of the load that completes next cycle
        ld_req_seen <= ld_mem_req_o;
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string field, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("Mismatch at time %0t: %s got %h expected %h", $time, field, got, exp);
        stop_with_failure("result differs from golden file");
    endtask

    task automatic check_load(input logic [lsu_pkg::TRANS_ID_BITS-1:0] tid,
                              input logic [lsu_pkg::XLEN-1:0] result,
                              input logic ex_valid,
                              input logic [lsu_pkg::CAUSE_W-1:0] cause,
                              input logic [lsu_pkg::XLEN-1:0] tval);
        logic [lsu_pkg::TRANS_ID_BITS-1:0] exp_tid;
        logic [lsu_pkg::XLEN-1:0]          exp_res;
        logic                              exp_ex;
        logic [lsu_pkg::CAUSE_W-1:0]       exp_cause;
        logic [lsu_pkg::XLEN-1:0]          exp_tval;
        if (ld_tid_q.size() == 0) begin
            stop_with_failure("load result came out while no load was expected");
        end else begin
            exp_tid   = ld_tid_q.pop_front();
            exp_res   = ld_res_q.pop_front();
            exp_ex    = ld_ex_q.pop_front();
            exp_cause = ld_cause_q.pop_front();
            exp_tval  = ld_tval_q.pop_front();
            if (tid !== exp_tid) report_mismatch("load trans_id", 64'(tid), 64'(exp_tid));
            if (result !== exp_res) report_mismatch("load result", result, exp_res);
            if (ex_valid !== exp_ex) report_mismatch("load ex_valid", 64'(ex_valid), 64'(exp_ex));
            // only a clean load reads memory
            if (ld_req_seen !== !exp_ex) begin
                report_mismatch("load memory request", 64'(ld_req_seen), 64'(!exp_ex));
            end
            // cause and tval only mean something on an exception
            if (exp_ex && cause !== exp_cause) begin
                report_mismatch("load cause", 64'(cause), 64'(exp_cause));
            end
            if (exp_ex && tval !== exp_tval) report_mismatch("load tval", tval, exp_tval);
        end
    endtask

    task automatic check_store(input logic [lsu_pkg::TRANS_ID_BITS-1:0] tid,
                               input logic ex_valid,
                               input logic [lsu_pkg::CAUSE_W-1:0] cause,
                               input logic [lsu_pkg::XLEN-1:0] tval);
        logic [lsu_pkg::TRANS_ID_BITS-1:0] exp_tid;
        logic                              exp_ex;
        logic [lsu_pkg::CAUSE_W-1:0]       exp_cause;
        logic [lsu_pkg::XLEN-1:0]          exp_tval;
        if (st_tid_q.size() == 0) begin
            stop_with_failure("store completed while no store was expected");
        end else begin
            exp_tid   = st_tid_q.pop_front();
            exp_ex    = st_ex_q.pop_front();
            exp_cause = st_cause_q.pop_front();
            exp_tval  = st_tval_q.pop_front();
            if (tid !== exp_tid) report_mismatch("store trans_id", 64'(tid), 64'(exp_tid));
            if (ex_valid !== exp_ex) report_mismatch("store ex_valid", 64'(ex_valid), 64'(exp_ex));
            if (exp_ex && cause !== exp_cause) begin
                report_mismatch("store cause", 64'(cause), 64'(exp_cause));
            end
            if (exp_ex && tval !== exp_tval) report_mismatch("store tval", tval, exp_tval);
        end
    endtask

    // --------------------
    // monitors
    // --------------------
    always @(posedge clk_i) begin
        if (rst_ni) begin
            if (load_valid_o) begin
                check_load(load_trans_id_o, load_result_o, load_ex_valid_o,
                           load_ex_cause_o, load_ex_tval_o);
            end
            if (store_valid_o) begin
                check_store(store_trans_id_o, store_ex_valid_o, store_ex_cause_o,
                            store_ex_tval_o);
            end
            cycle_count <= cycle_count + 1;
            if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
                stop_with_failure("timeout: results did not arrive within the cycle limit");
            end
        end
    end

    function automatic logic line_flushes(input int i);
        if (i >= num_ops) return 1'b0;
        return golden[1 + i*FIELDS + 6][0];
    endfunction

    function automatic logic line_trans_en(input int i);
        return golden[1 + i*FIELDS + 5][0];
    endfunction

    task automatic set_idle();
        fu_valid_i = 1'b0;
        flush_i    = 1'b0;
    endtask

    task automatic drive_line(input int i);
        int base;
        base = 1 + i*FIELDS;
        fu_valid_i             = 1'b1;
        fu_op_i                = golden[base][lsu_pkg::OP_W-1:0];
        fu_operand_a_i         = golden[base + 1];
        fu_imm_i               = golden[base + 2];
        fu_operand_b_i         = golden[base + 3];
        fu_trans_id_i          = golden[base + 4][lsu_pkg::TRANS_ID_BITS-1:0];
        en_ld_st_translation_i = golden[base + 5][0];
        flush_i                = golden[base + 6][0];
        // ex field f marks an op lost to flush
        if (golden[base + 7][3:0] != 4'hf) begin
            if (!fu_op_i[lsu_pkg::OP_W-1]) begin
                ld_tid_q.push_back(fu_trans_id_i);
                ld_ex_q.push_back(golden[base + 7][0]);
                ld_cause_q.push_back(golden[base + 8][lsu_pkg::CAUSE_W-1:0]);
                ld_tval_q.push_back(golden[base + 9]);
                ld_res_q.push_back(golden[base + 10]);
            end else begin
                st_tid_q.push_back(fu_trans_id_i);
                st_ex_q.push_back(golden[base + 7][0]);
                st_cause_q.push_back(golden[base + 8][lsu_pkg::CAUSE_W-1:0]);
                st_tval_q.push_back(golden[base + 9]);
            end
        end
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        int gap;
        clk_i                  = 1'b0;
        rst_ni                 = 1'b0;
        flush_i                = 1'b0;
        en_ld_st_translation_i = 1'b0;
        fu_valid_i             = 1'b0;
        fu_op_i                = '0;
        fu_operand_a_i         = '0;
        fu_imm_i               = '0;
        fu_operand_b_i         = '0;
        fu_trans_id_i          = '0;
        ld_mem_rdata_i         = '0;
        ld_req_seen            = 1'b0;
        cycle_count            = 0;
        cycle_limit            = 0;
        seed                   = 9050;
        // byte at address a holds a*7+3
        for (int i = 0; i < 64; i++) begin
            for (int j = 0; j < 8; j++) begin
                mem[i].bytes[j] = 8'(((i*8 + j)*7 + 3) % 256);
            end
        end
        $readmemh("tb/lsu_golden.mem", golden);
        num_ops     = int'(golden[0][15:0]);
        cycle_limit = num_ops*3 + 50;
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        for (int i = 0; i < num_ops; i++) begin
            // ops leading into a flush go back to back so the flushed set is fixed
            gap = 0;
            if (!line_flushes(i) && !line_flushes(i + 1)) begin
                gap = ($random(seed) & 32'h7fffffff) % 3;
            end
            // translation enable is used one cycle after acceptance
            if (i > 0 && gap == 0 && line_trans_en(i) != line_trans_en(i - 1)) begin
                gap = 1;
            end
            repeat (gap) begin
                @(negedge clk_i);
                set_idle();
            end
            @(negedge clk_i);
            drive_line(i);
        end
        @(negedge clk_i);
        set_idle();
        // outstanding results arrive here or the monitor times out
        while (ld_tid_q.size() != 0 || st_tid_q.size() != 0) begin
            @(negedge clk_i);
        end
        // stray results from flushed ops would show up here
        repeat (6) @(negedge clk_i);
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/lsu_golden.mem
// columns: op operand_a imm operand_b trans_id trans_en flush ex cause tval result
// first word is the op count, ex f means the op is flushed and gives no result
20
0 40 1 0 1 0 0 0 0 0 FFFFFFFFFFFFFFCA
4 50 FFFFFFFFFFFFFFF7 0 2 0 0 0 0 0 F4
1 40 2 0 3 0 0 0 0 0 FFFFFFFFFFFFD8D1
5 40 6 0 4 0 0 0 0 0 F4ED
2 40 4 0 5 0 0 0 0 0 FFFFFFFFF4EDE6DF
6 40 0 0 6 0 0 0 0 0 D8D1CAC3
3 40 0 0 7 0 0 0 0 0 F4EDE6DFD8D1CAC3
0 10 0 0 0 0 0 0 0 0 73
1 10 0 0 1 0 0 0 0 0 7A73
2 0 4 0 2 0 0 0 0 0 342D261F
8 80 3 55 3 0 0 0 0 0 0
3 80 0 0 4 0 0 0 0 0 B4ADA69F55918A83
9 80 6 BEEF 5 0 0 0 0 0 0
3 80 0 0 6 0 0 0 0 0 BEEFA69F55918A83
A 88 0 1122334455667788 7 0 0 0 0 0 0
3 88 0 0 0 0 0 0 0 0 ECE5DED755667788
B 90 0 0123456789ABCDEF 1 0 0 0 0 0 0
3 90 0 0 2 0 0 0 0 0 0123456789ABCDEF
1 41 0 0 3 0 0 1 4 41 0
A 80 2 FFFFFFFF 4 0 0 1 6 82 0
3 80 0 0 5 0 0 0 0 0 BEEFA69F55918A83
3 40 4 0 6 0 0 1 4 44 0
3 4000000040 0 0 7 1 0 1 5 4000000040 0
8 4000000040 0 AA 0 1 0 1 7 4000000040 0
3 4000000040 0 0 1 0 0 0 0 0 F4EDE6DFD8D1CAC3
1 4000000040 1 0 2 0 0 1 4 4000000041 0
2 4000000040 2 0 3 1 0 1 5 4000000042 0
3 0 0 0 4 0 0 f 0 0 0
0 0 1 0 5 0 0 f 0 0 0
B 0 0 FFFF 6 0 1 f 0 0 0
3 0 0 0 7 0 0 0 0 0 342D261F18110A03
4 0 7 0 0 0 0 0 0 0 34

//--- sources.f
logic/lsu_pkg.sv
logic/address_gen.sv
logic/bare_mmu.sv
logic/load_unit.sv
logic/store_unit.sv
logic/load_store_unit.sv
tb/tb_load_store_unit.sv

//--- run.sh
#!/bin/sh
# build and run the load/store unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sources.f --top-module tb_load_store_unit -o sim_lsu \
    && ./obj_dir/sim_lsu | tee /dev/stderr | grep "Test passed" > /dev/null \
    && echo "run ok" \
    || { echo "run FAILED"; exit 1; }
